/* common/coreCfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath
`define CORE_DATA_W      32   // Data and instruction word
`define CORE_REG_CNT     16
`define CORE_REG_IDX_W   4    // Register index bits

// Memories, word addressed
`define CORE_IMEM_DEPTH  1024
`define CORE_IMEM_AW     10
`define CORE_DMEM_DEPTH  1024
`define CORE_DMEM_AW     10

// Instruction fields
`define CORE_OPC_W       5
`define CORE_IMM_W       18   // Sign extended
`define CORE_TARGET_W    27   // Zero extended, absolute

`endif

/* common/isaPkg.sv */
`include "coreCfg.svh"

package isaPkg;

    typedef enum logic [`CORE_OPC_W-1:0] {
        opAdd = 5'b00000,
        opSub = 5'b00001,
        opCmp = 5'b00101,  // Sets flags only
        opAnd = 5'b00110,
        opOr  = 5'b00111,
        opNot = 5'b01000,
        opMov = 5'b01001,
        opLsl = 5'b01010,
        opLsr = 5'b01011,
        opAsr = 5'b01100,
        opNop = 5'b01101,
        opLd  = 5'b01110,
        opSt  = 5'b01111,
        opBeq = 5'b10000,
        opBgt = 5'b10001,
        opB   = 5'b10010
    } opcode_t;

    // Immediate overlays rs2 and low bits, branch target overlays everything below opcode
    typedef struct packed {
        opcode_t                              opcode;  // 31..27
        logic                                 isImm;   // 26
        logic [`CORE_REG_IDX_W-1:0]           rd;      // 25..22
        logic [`CORE_REG_IDX_W-1:0]           rs1;     // 21..18
        logic [`CORE_REG_IDX_W-1:0]           rs2;     // 17..14
        logic [`CORE_IMM_W-`CORE_REG_IDX_W-1:0] immLow;  // 13..0
    } instr_t;

    typedef struct packed {
        logic    isWb;
        logic    isLd;
        logic    isSt;
        logic    isBeq;
        logic    isBgt;
        logic    isUbranch;
        logic    isCmp;
        logic    isImm;
        opcode_t aluOp;
    } ctrl_t;

    typedef struct packed {
        logic                       valid;
        logic [`CORE_REG_IDX_W-1:0] idx;
        logic [`CORE_DATA_W-1:0]    data;
    } regWrite_t;

    typedef struct packed {
        logic                     valid;
        logic [`CORE_DMEM_AW-1:0] addr;  // Word address
        logic [`CORE_DATA_W-1:0]  data;
    } memWrite_t;

endpackage

/* common/pipePkg.sv */
`include "coreCfg.svh"

package pipePkg;

    // Fetch to decode
    typedef struct packed {
        logic                    valid;
        logic [`CORE_DATA_W-1:0] pc;
        isaPkg::instr_t          instr;
    } ifId_t;

    // Decode to execute, operands already selected
    typedef struct packed {
        logic                       valid;
        isaPkg::ctrl_t              ctrl;
        logic [`CORE_REG_IDX_W-1:0] rd;
        logic [`CORE_DATA_W-1:0]    opA;
        logic [`CORE_DATA_W-1:0]    opB;    // Register or immediate
        logic [`CORE_DATA_W-1:0]    stVal;  // Value of rd for st
        logic [`CORE_DATA_W-1:0]    target;
    } idEx_t;

    // Execute to memory
    typedef struct packed {
        logic                       valid;
        isaPkg::ctrl_t              ctrl;
        logic [`CORE_REG_IDX_W-1:0] rd;
        logic [`CORE_DATA_W-1:0]    aluRes;  // Also the ld/st address
        logic [`CORE_DATA_W-1:0]    stVal;
    } exMem_t;

    // Memory to writeback, load data comes straight from the memory
    typedef struct packed {
        logic                       valid;
        isaPkg::ctrl_t              ctrl;
        logic [`CORE_REG_IDX_W-1:0] rd;
        logic [`CORE_DATA_W-1:0]    aluRes;
    } memWb_t;

endpackage

/* hw/fetchUnit.sv */
`timescale 1ns/10ps
`include "coreCfg.svh"

module fetchUnit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     run,
    input  logic                     progWrite,
    input  logic [`CORE_IMEM_AW-1:0] progAddr,
    input  logic [`CORE_DATA_W-1:0]  progData,
    input  logic                     branchTaken,
    input  logic [`CORE_DATA_W-1:0]  branchTarget,
    output pipePkg::ifId_t           ifId
);
    import isaPkg::*;

    logic [`CORE_DATA_W-1:0] imem [`CORE_IMEM_DEPTH];
    logic [`CORE_DATA_W-1:0] pc;         // Next sequential fetch address
    logic [`CORE_DATA_W-1:0] fetchAddr;
    logic [`CORE_DATA_W-1:0] slotPc;
    logic                    slotValid;
    instr_t                  instrWord;

    // Redirect replaces the third slot after the branch
    assign fetchAddr = branchTaken ? branchTarget : pc;

    always_ff @(posedge clk) begin
        if (progWrite) begin
            imem[progAddr] <= progData;  // Program load port
        end
        instrWord <= imem[fetchAddr[`CORE_IMEM_AW-1:0]];  // Sync read
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc        <= '0;
            slotValid <= 1'b0;
        end else if (!run) begin
            pc        <= '0;  // Hold at program start
            slotValid <= 1'b0;
        end else begin
            pc        <= fetchAddr + 1'b1;
            slotValid <= 1'b1;
            slotPc    <= fetchAddr;
        end
    end

    always_comb begin
        ifId.valid = slotValid;
        ifId.pc    = slotPc;
        ifId.instr = instrWord;
    end

    // Loading while running would corrupt instructions in flight
    loadWhileRun: assert property (@(posedge clk) disable iff (reset) !(progWrite && run))
        else $error("progWrite while run is high");

endmodule

/* hw/regFile.sv */
`timescale 1ns/10ps
`include "coreCfg.svh"

module regFile (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`CORE_REG_IDX_W-1:0] rdIdxA,
    input  logic [`CORE_REG_IDX_W-1:0] rdIdxB,
    input  logic [`CORE_REG_IDX_W-1:0] rdIdxS,
    output logic [`CORE_DATA_W-1:0]    rdDataA,
    output logic [`CORE_DATA_W-1:0]    rdDataB,
    output logic [`CORE_DATA_W-1:0]    rdDataS,
    input  isaPkg::regWrite_t          wr
);
    logic [`CORE_DATA_W-1:0] regs [`CORE_REG_CNT];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `CORE_REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid) begin
            regs[wr.idx] <= wr.data;
        end
    end

    // Writeback bypass, decode sees this cycle's write
    assign rdDataA = (wr.valid && wr.idx == rdIdxA) ? wr.data : regs[rdIdxA];
    assign rdDataB = (wr.valid && wr.idx == rdIdxB) ? wr.data : regs[rdIdxB];
    assign rdDataS = (wr.valid && wr.idx == rdIdxS) ? wr.data : regs[rdIdxS];

    wrIdxKnown: assert property (@(posedge clk) disable iff (reset)
        wr.valid |-> !$isunknown(wr.idx))
        else $error("Register write with unknown index");

endmodule

/* hw/decodeUnit.sv */
`timescale 1ns/10ps
`include "coreCfg.svh"

module decodeUnit (
    input  logic                       clk,
    input  logic                       reset,
    input  pipePkg::ifId_t             ifId,
    output logic [`CORE_REG_IDX_W-1:0] rdIdxA,
    output logic [`CORE_REG_IDX_W-1:0] rdIdxB,
    output logic [`CORE_REG_IDX_W-1:0] rdIdxS,
    input  logic [`CORE_DATA_W-1:0]    rdDataA,
    input  logic [`CORE_DATA_W-1:0]    rdDataB,
    input  logic [`CORE_DATA_W-1:0]    rdDataS,
    output pipePkg::idEx_t             idEx
);
    import isaPkg::*;

    ctrl_t                   ctrl;
    logic                    knownOp;
    logic [`CORE_DATA_W-1:0] immExt;
    logic [`CORE_DATA_W-1:0] targetExt;

    assign rdIdxA = ifId.instr.rs1;
    assign rdIdxB = ifId.instr.rs2;
    assign rdIdxS = ifId.instr.rd;  // St data comes from rd

    assign immExt = {{(`CORE_DATA_W-`CORE_IMM_W){ifId.instr[`CORE_IMM_W-1]}},
                     ifId.instr[`CORE_IMM_W-1:0]};
    assign targetExt = {{(`CORE_DATA_W-`CORE_TARGET_W){1'b0}},
                        ifId.instr[`CORE_TARGET_W-1:0]};

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = opNop;
        knownOp    = 1'b1;
        case (ifId.instr.opcode)
            opAdd, opSub, opAnd, opOr, opNot, opMov, opLsl, opLsr, opAsr: begin
                ctrl.isWb  = 1'b1;
                ctrl.isImm = ifId.instr.isImm;
                ctrl.aluOp = ifId.instr.opcode;
            end
            opCmp: begin
                ctrl.isCmp = 1'b1;
                ctrl.isImm = ifId.instr.isImm;
                ctrl.aluOp = opSub;
            end
            opLd, opSt: begin
                ctrl.isWb  = (ifId.instr.opcode == opLd);
                ctrl.isLd  = (ifId.instr.opcode == opLd);
                ctrl.isSt  = (ifId.instr.opcode == opSt);
                ctrl.isImm = ifId.instr.isImm;
                ctrl.aluOp = opAdd;  // Address is rs1 + offset
            end
            opBeq:   ctrl.isBeq = 1'b1;
            opBgt:   ctrl.isBgt = 1'b1;
            opB:     ctrl.isUbranch = 1'b1;
            opNop:   ;
            default: knownOp = 1'b0;  // Behaves as nop
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idEx.valid <= 1'b0;
        end else begin
            idEx.valid  <= ifId.valid;
            idEx.ctrl   <= ctrl;
            idEx.rd     <= ifId.instr.rd;
            idEx.opA    <= rdDataA;
            idEx.opB    <= ctrl.isImm ? immExt : rdDataB;
            idEx.stVal  <= rdDataS;
            idEx.target <= targetExt;
        end
    end

    badOpcode: assert property (@(posedge clk) disable iff (reset) ifId.valid |-> knownOp)
        else $error("Unknown opcode %b decoded as nop", ifId.instr.opcode);

endmodule

/* hw/executeUnit.sv */
`timescale 1ns/10ps
`include "coreCfg.svh"

module executeUnit (
    input  logic                    clk,
    input  logic                    reset,
    input  pipePkg::idEx_t          idEx,
    output pipePkg::exMem_t         exMem,
    output logic                    branchTaken,
    output logic [`CORE_DATA_W-1:0] branchTarget
);
    import isaPkg::*;

    localparam int ShW = $clog2(`CORE_DATA_W);

    logic [`CORE_DATA_W-1:0] aluRes;
    logic [ShW-1:0]          shAmt;
    logic                    flagEq;
    logic                    flagGt;
    logic                    takeNow;

    assign shAmt = idEx.opB[ShW-1:0];  // Shift by low bits of B

    always_comb begin
        case (idEx.ctrl.aluOp)
            opAdd:   aluRes = idEx.opA + idEx.opB;
            opSub:   aluRes = idEx.opA - idEx.opB;
            opAnd:   aluRes = idEx.opA & idEx.opB;
            opOr:    aluRes = idEx.opA | idEx.opB;
            opNot:   aluRes = ~idEx.opB;
            opMov:   aluRes = idEx.opB;
            opLsl:   aluRes = idEx.opA << shAmt;
            opLsr:   aluRes = idEx.opA >> shAmt;
            opAsr:   aluRes = $signed(idEx.opA) >>> shAmt;
            default: aluRes = '0;  // Branches and nop
        endcase
    end

    // Flags come from the register, so a cmp right before is already visible
    assign takeNow = idEx.valid && ((idEx.ctrl.isBeq && flagEq) ||
                                    (idEx.ctrl.isBgt && flagGt) ||
                                    idEx.ctrl.isUbranch);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exMem.valid <= 1'b0;
            flagEq      <= 1'b0;
            flagGt      <= 1'b0;
            branchTaken <= 1'b0;
        end else begin
            exMem.valid  <= idEx.valid;
            exMem.ctrl   <= idEx.ctrl;
            exMem.rd     <= idEx.rd;
            exMem.aluRes <= aluRes;
            exMem.stVal  <= idEx.stVal;
            if (idEx.valid && idEx.ctrl.isCmp) begin
                flagEq <= (idEx.opA == idEx.opB);
                flagGt <= ($signed(idEx.opA) > $signed(idEx.opB));  // Signed compare
            end
            branchTaken  <= takeNow;
            branchTarget <= idEx.target;
        end
    end

    // A taken branch in a delay slot breaks the redirect timing
    branchInSlot: assert property (@(posedge clk) disable iff (reset)
        branchTaken |=> !branchTaken)
        else $error("Taken branch in the first delay slot");

endmodule

/* hw/memWriteback.sv */
`timescale 1ns/10ps
`include "coreCfg.svh"

module memWriteback (
    input  logic               clk,
    input  logic               reset,
    input  pipePkg::exMem_t    exMem,
    output isaPkg::regWrite_t  regWr,
    output isaPkg::memWrite_t  storeTrace
);
    logic [`CORE_DATA_W-1:0]  dmem [`CORE_DMEM_DEPTH];
    logic [`CORE_DMEM_AW-1:0] memAddr;
    logic [`CORE_DATA_W-1:0]  ldData;
    logic                     doStore;
    pipePkg::memWb_t          memWb;

    assign memAddr = exMem.aluRes[`CORE_DMEM_AW-1:0];  // Word address
    assign doStore = exMem.valid && exMem.ctrl.isSt;

    always_ff @(posedge clk) begin
        if (doStore) begin
            dmem[memAddr] <= exMem.stVal;
        end
        ldData <= dmem[memAddr];  // Lines up with memWb
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            memWb.valid      <= 1'b0;
            storeTrace.valid <= 1'b0;
        end else begin
            memWb.valid      <= exMem.valid;
            memWb.ctrl       <= exMem.ctrl;
            memWb.rd         <= exMem.rd;
            memWb.aluRes     <= exMem.aluRes;
            storeTrace.valid <= doStore;
            storeTrace.addr  <= memAddr;
            storeTrace.data  <= exMem.stVal;
        end
    end

    // Writeback select
    always_comb begin
        regWr.valid = memWb.valid && memWb.ctrl.isWb;
        regWr.idx   = memWb.rd;
        regWr.data  = memWb.ctrl.isLd ? ldData : memWb.aluRes;
    end

endmodule

/* hw/riscCore.sv */
`timescale 1ns/10ps
`include "coreCfg.svh"

module riscCore (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     run,
    input  logic                     progWrite,
    input  logic [`CORE_IMEM_AW-1:0] progAddr,
    input  logic [`CORE_DATA_W-1:0]  progData,
    output isaPkg::regWrite_t        regTrace,
    output isaPkg::memWrite_t        storeTrace
);
    import pipePkg::*;

    ifId_t                      ifId;
    idEx_t                      idEx;
    exMem_t                     exMem;
    logic                       branchTaken;
    logic [`CORE_DATA_W-1:0]    branchTarget;
    logic [`CORE_REG_IDX_W-1:0] rdIdxA, rdIdxB, rdIdxS;
    logic [`CORE_DATA_W-1:0]    rdDataA, rdDataB, rdDataS;

    fetchUnit uFetch (
        .clk, .reset, .run, .progWrite, .progAddr, .progData,
        .branchTaken, .branchTarget, .ifId
    );

    regFile uRegs (
        .clk, .reset, .rdIdxA, .rdIdxB, .rdIdxS,
        .rdDataA, .rdDataB, .rdDataS,
        .wr(regTrace)  // Writeback port doubles as the trace
    );

    decodeUnit uDecode (
        .clk, .reset, .ifId, .rdIdxA, .rdIdxB, .rdIdxS,
        .rdDataA, .rdDataB, .rdDataS, .idEx
    );

    executeUnit uExec (.clk, .reset, .idEx, .exMem, .branchTaken, .branchTarget);

    memWriteback uMemWb (.clk, .reset, .exMem, .regWr(regTrace), .storeTrace);

endmodule

/* dv/coreChecker.sv */
`timescale 1ns/10ps
`include "coreCfg.svh"

module coreChecker (
    input  logic              clk,
    input  logic              reset,
    input  logic              armed,
    input  isaPkg::regWrite_t regTrace,
    input  isaPkg::memWrite_t storeTrace,
    output int                valueErrors,
    output int                otherErrors
);
    logic [35:0] regExp [$];    // {idx, data} in program order
    logic [41:0] storeExp [$];  // {addr, data}
    int          valueErrs = 0;
    int          otherErrs = 0;

    assign valueErrors = valueErrs;
    assign otherErrors = otherErrs;

    task automatic clearExpect();
        regExp.delete();
        storeExp.delete();
    endtask

    task automatic expectReg(input logic [35:0] ev);
        regExp.push_back(ev);
    endtask

    task automatic expectStore(input logic [41:0] ev);
        storeExp.push_back(ev);
    endtask

    function automatic bit allSeen();
        return regExp.size() == 0 && storeExp.size() == 0;
    endfunction

    task automatic checkReg();
        logic [35:0] exp;
        if (regExp.size() == 0) begin
            $display("ERROR t=%0t: unexpected register write r%0d = %h",
                     $time, regTrace.idx, regTrace.data);
            otherErrs++;
        end else begin
            exp = regExp.pop_front();
            if (regTrace.idx !== exp[35:32]) begin
                $display("CHECK FAILED t=%0t regTrace.idx exp=%0d got=%0d",
                         $time, exp[35:32], regTrace.idx);
                valueErrs++;
            end
            if (regTrace.data !== exp[31:0]) begin
                $display("CHECK FAILED t=%0t regTrace.data exp=%h got=%h",
                         $time, exp[31:0], regTrace.data);
                valueErrs++;
            end
        end
    endtask

    task automatic checkStore();
        logic [41:0] exp;
        if (storeExp.size() == 0) begin
            $display("ERROR t=%0t: unexpected store to %0d = %h",
                     $time, storeTrace.addr, storeTrace.data);
            otherErrs++;
        end else begin
            exp = storeExp.pop_front();
            if (storeTrace.addr !== exp[41:32]) begin
                $display("CHECK FAILED t=%0t storeTrace.addr exp=%0d got=%0d",
                         $time, exp[41:32], storeTrace.addr);
                valueErrs++;
            end
            if (storeTrace.data !== exp[31:0]) begin
                $display("CHECK FAILED t=%0t storeTrace.data exp=%h got=%h",
                         $time, exp[31:0], storeTrace.data);
                valueErrs++;
            end
        end
    endtask

    // Traces are sampled at the edge, before the DUT registers move
    always @(posedge clk) begin
        if (reset) begin
            if (regTrace.valid || storeTrace.valid) begin
                $display("ERROR t=%0t: trace valid high while reset is held", $time);
                otherErrs++;
            end
        end else if (armed) begin
            if (regTrace.valid) begin
                checkReg();
            end
            if (storeTrace.valid) begin
                checkStore();
            end
        end
    end

endmodule

/* dv/coreTb.sv */
`timescale 1ns/10ps
`include "coreCfg.svh"

module coreTb;
    import isaPkg::*;

    localparam int NumProgs = 5;
    localparam int WaitLimit = 300;  // Cycles allowed per program

    logic                     clk = 1'b0;
    logic                     reset;
    logic                     run;
    logic                     progWrite;
    logic [`CORE_IMEM_AW-1:0] progAddr;
    logic [`CORE_DATA_W-1:0]  progData;
    logic                     armed;
    regWrite_t                regTrace;
    memWrite_t                storeTrace;
    int                       valueErrors;
    int                       otherErrors;
    int                       timeoutErrors = 0;

    logic [31:0] wordTab [NumProgs][$];   // Program image
    logic [35:0] regTab [NumProgs][$];    // Expected {idx, data}
    logic [41:0] storeTab [NumProgs][$];  // Expected {addr, data}
    int          resetAfter [NumProgs];   // Cycles before a mid-run reset or 0

    always #20 clk = ~clk;  // 40 ns period

    riscCore i_dut (
        .clk, .reset, .run, .progWrite, .progAddr, .progData, .regTrace, .storeTrace
    );

    coreChecker i_chk (
        .clk, .reset, .armed, .regTrace, .storeTrace, .valueErrors, .otherErrors
    );

    function automatic logic [31:0] encR(opcode_t op, int rd, int rs1, int rs2);
        return {op, 1'b0, rd[3:0], rs1[3:0], rs2[3:0], 14'd0};
    endfunction

    function automatic logic [31:0] encI(opcode_t op, int rd, int rs1, int imm);
        return {op, 1'b1, rd[3:0], rs1[3:0], imm[17:0]};
    endfunction

    function automatic logic [31:0] encB(opcode_t op, int target);
        return {op, target[26:0]};
    endfunction

    function automatic logic [31:0] nopW();
        return {opNop, 27'd0};
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #2;  // Drive after the edge
    endtask

    task automatic buildTables();
        // ALU ops spaced three slots from their producers
        wordTab[0] = '{encI(opMov, 1, 0, 5), encI(opMov, 2, 0, -3), encI(opMov, 3, 0, 2),
                       nopW(), encR(opAdd, 4, 1, 2), encR(opSub, 5, 1, 2),
                       encR(opAnd, 6, 1, 2), encR(opOr, 7, 1, 2), encR(opNot, 8, 0, 1),
                       encR(opLsl, 9, 1, 3), encR(opLsr, 10, 2, 3), encR(opAsr, 11, 2, 3),
                       encI(opAdd, 12, 1, -100), encB(opB, 13), nopW(), nopW()};
        regTab[0] = '{{4'd1, 32'd5}, {4'd2, 32'hFFFFFFFD}, {4'd3, 32'd2}, {4'd4, 32'd2},
                      {4'd5, 32'd8}, {4'd6, 32'd5}, {4'd7, 32'hFFFFFFFD},
                      {4'd8, 32'hFFFFFFFA}, {4'd9, 32'd20}, {4'd10, 32'h3FFFFFFF},
                      {4'd11, 32'hFFFFFFFF}, {4'd12, 32'hFFFFFFA1}};
        storeTab[0] = {};
        resetAfter[0] = 0;
        // Store then load back
        wordTab[1] = '{encI(opMov, 1, 0, 'h1234), encI(opMov, 2, 0, 7), encI(opMov, 3, 0, -1),
                       nopW(), encI(opSt, 1, 2, 3), encI(opSt, 3, 2, -2),
                       encI(opLd, 4, 2, 3), encI(opLd, 5, 2, -2), nopW(), nopW(),
                       encR(opAdd, 6, 4, 5), encB(opB, 11), nopW(), nopW()};
        regTab[1] = '{{4'd1, 32'h1234}, {4'd2, 32'd7}, {4'd3, 32'hFFFFFFFF},
                      {4'd4, 32'h1234}, {4'd5, 32'hFFFFFFFF}, {4'd6, 32'h1233}};
        storeTab[1] = '{{10'd10, 32'h1234}, {10'd5, 32'hFFFFFFFF}};
        resetAfter[1] = 0;
        // cmp with beq and bgt both taken and not taken
        wordTab[2] = '{encI(opMov, 1, 0, 10), encI(opMov, 2, 0, 3), nopW(), nopW(),
                       encR(opCmp, 0, 1, 2), encB(opBeq, 20), encI(opMov, 3, 0, 1),
                       encI(opMov, 4, 0, 2), encB(opBgt, 12), encI(opMov, 5, 0, 3),
                       encI(opMov, 6, 0, 4), encI(opMov, 7, 0, 99), encI(opCmp, 0, 1, 10),
                       encB(opBgt, 20), encI(opMov, 8, 0, 5), encI(opMov, 9, 0, 6),
                       encB(opBeq, 20), encI(opMov, 10, 0, 7), encI(opMov, 11, 0, 8),
                       encI(opMov, 12, 0, 77), encI(opMov, 13, 0, 9), encB(opB, 21),
                       nopW(), nopW()};
        regTab[2] = '{{4'd1, 32'd10}, {4'd2, 32'd3}, {4'd3, 32'd1}, {4'd4, 32'd2},
                      {4'd5, 32'd3}, {4'd6, 32'd4}, {4'd8, 32'd5}, {4'd9, 32'd6},
                      {4'd10, 32'd7}, {4'd11, 32'd8}, {4'd13, 32'd9}};
        storeTab[2] = {};
        resetAfter[2] = 0;
        // b over a block
        wordTab[3] = '{encI(opMov, 1, 0, 11), encB(opB, 6), encI(opMov, 2, 0, 22),
                       encI(opMov, 3, 0, 33), encI(opMov, 4, 0, 44), encI(opMov, 5, 0, 55),
                       encI(opMov, 6, 0, 66), nopW(), nopW(), encR(opSub, 7, 6, 1),
                       encB(opB, 10), nopW(), nopW()};
        regTab[3] = '{{4'd1, 32'd11}, {4'd2, 32'd22}, {4'd3, 32'd33}, {4'd6, 32'd66},
                      {4'd7, 32'd55}};
        storeTab[3] = {};
        resetAfter[3] = 0;
        // Reset hits with both stores and a load in flight, rerun from address 0
        wordTab[4] = wordTab[1];
        regTab[4] = regTab[1];
        storeTab[4] = storeTab[1];
        resetAfter[4] = 7;
    endtask

    task automatic loadProgram(int p);
        for (int a = 0; a < wordTab[p].size(); a++) begin
            progWrite = 1'b1;
            progAddr  = a[`CORE_IMEM_AW-1:0];
            progData  = wordTab[p][a];
            nextCycle();
        end
        progWrite = 1'b0;
    endtask

    task automatic runTest(int p);
        int cyc;
        i_chk.clearExpect();
        for (int i = 0; i < regTab[p].size(); i++) begin
            i_chk.expectReg(regTab[p][i]);
        end
        for (int i = 0; i < storeTab[p].size(); i++) begin
            i_chk.expectStore(storeTab[p][i]);
        end
        loadProgram(p);
        if (resetAfter[p] > 0) begin
            run = 1'b1;  // Unchecked partial run
            repeat (resetAfter[p]) nextCycle();
            reset = 1'b1;
            run   = 1'b0;
            repeat (4) nextCycle();
            reset = 1'b0;
        end
        armed = 1'b1;
        run   = 1'b1;
        cyc   = 0;
        while (!i_chk.allSeen() && cyc < WaitLimit) begin
            nextCycle();
            cyc++;
        end
        if (!i_chk.allSeen()) begin
            $display("ERROR t=%0t: program %0d timed out before all events were seen",
                     $time, p);
            timeoutErrors++;
        end
        repeat (8) nextCycle();  // Window for extra events
        armed = 1'b0;
        run   = 1'b0;
        repeat (6) nextCycle();  // Pipeline drain
    endtask

    initial begin
        reset     = 1'b1;
        run       = 1'b0;
        progWrite = 1'b0;
        progAddr  = '0;
        progData  = '0;
        armed     = 1'b0;
        buildTables();
        repeat (4) nextCycle();
        reset = 1'b0;
        for (int p = 0; p < NumProgs; p++) begin
            runTest(p);
        end
        $display("Errors: value=%0d other=%0d timeout=%0d",
                 valueErrors, otherErrors, timeoutErrors);
        if (valueErrors + otherErrors + timeoutErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+common
common/isaPkg.sv
common/pipePkg.sv
hw/fetchUnit.sv
hw/regFile.sv
hw/decodeUnit.sv
hw/executeUnit.sv
hw/memWriteback.sv
hw/riscCore.sv
dv/coreChecker.sv
dv/coreTb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module coreTb \
    --Mdir obj_dir -o coreSim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/coreSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "All tests passed!" sim.log; then
    exit 0
fi
exit 1
